// ==== common/dma_defines.svh ====
// DMA engine width, depth and destination region macros
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ==================================================
// Datapath sizing
// ==================================================

// Word width of the AXI read port and both local ports
`define DMA_DATA_W      32

// Bytes per word, also the address step between words
`define DMA_WORD_BYTES  4

// Words buffered between read engine and local writer
`define DMA_FIFO_DEPTH  8

// ==================================================
// Destination regions, top nibble of the dst address
// ==================================================
`define DMA_REGION_TILE 1
`define DMA_REGION_CFG  2

`endif

// ==== common/dma_pkg.sv ====
// DMA shared vector typedefs, FSM state enums and packed port structs
`include "dma_defines.svh"

package dma_pkg;

    // ==================================================
    // Plain vector types
    // ==================================================
    typedef logic [`DMA_DATA_W-1:0] word_t;
    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            word_count_t;
    // Offset inside one 4 KB tile bank
    typedef logic [11:0]            tile_addr_t;
    typedef logic [1:0]             bank_sel_t;
    typedef logic [3:0]             region_t;

    // ==================================================
    // FSM states
    // ==================================================
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_DONE} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_WAIT, WR_WRITE, WR_DONE} wr_state_t;

    // ==================================================
    // Port bundles
    // ==================================================
    // CSR configuration, size in bytes
    typedef struct packed {
        addr_t               src;
        addr_t               dst;
        logic [31:0]         size;
    } dma_cfg_t;

    // AXI4-Lite read master to slave
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axi_rd_req_t;

    // AXI4-Lite read slave to master
    typedef struct packed {
        logic  arready;
        word_t rdata;
        logic  rvalid;
    } axi_rd_rsp_t;

    // Tile memory write strobe
    typedef struct packed {
        tile_addr_t addr;
        bank_sel_t  bank;
        logic       we;
        word_t      data;
    } tile_wr_t;

    // PE-array configuration write strobe
    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t data;
    } cfg_wr_t;

endpackage

// ==== dma/dma_local_writer.sv ====
// Local writer FSM that drains the FIFO into tile memory or the config port
`include "dma_defines.svh"

module dma_local_writer
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        launch_i,
    input  addr_t       dst_i,
    input  word_count_t words_i,
    input  logic        fifo_empty_i,
    input  word_t       fifo_head_i,
    output logic        pop_o,
    output tile_wr_t    tile_o,
    output cfg_wr_t     cfg_o,
    output logic        finished_o
);

    wr_state_t   state_q;
    addr_t       addr_q;
    word_count_t remaining_q;
    region_t     region_q;
    word_t       data_q;
    logic        writing;
    logic        last_word;

    // ==================================================
    // Drain FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= WR_IDLE;
            addr_q      <= '0;
            remaining_q <= '0;
            region_q    <= '0;
        end else begin
            case (state_q)
                WR_IDLE, WR_DONE: begin
                    if (launch_i) begin
                        addr_q      <= dst_i;
                        remaining_q <= words_i;
                        // Region is fixed per transfer, not per word
                        region_q    <= dst_i[31:28];
                        state_q     <= WR_WAIT;
                    end
                end

                WR_WAIT: begin
                    // Pop lands in the data register on this edge
                    if (!fifo_empty_i) begin
                        state_q <= WR_WRITE;
                    end
                end

                WR_WRITE: begin
                    addr_q      <= addr_q + addr_t'(`DMA_WORD_BYTES);
                    remaining_q <= remaining_q - 1'b1;
                    if (last_word) begin
                        state_q <= WR_DONE;
                    end else begin
                        state_q <= WR_WAIT;
                    end
                end

                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Latched word, payload only
    always_ff @(posedge clk) begin
        if (pop_o) begin
            data_q <= fifo_head_i;
        end
    end

    assign pop_o     = (state_q == WR_WAIT) && !fifo_empty_i;
    assign writing   = (state_q == WR_WRITE);
    assign last_word = (remaining_q == word_count_t'(1));

    // Pulses on the edge of the last strobe, done follows a cycle later
    assign finished_o = writing && last_word;

    // ==================================================
    // Local write ports
    // ==================================================
    // Bank offset from bits 11:0, bank number from bits 13:12
    assign tile_o.addr = addr_q[11:0];
    assign tile_o.bank = addr_q[13:12];
    assign tile_o.data = data_q;
    assign tile_o.we   = writing && (region_q == region_t'(`DMA_REGION_TILE));

    // Config port takes the full byte address
    assign cfg_o.addr = addr_q;
    assign cfg_o.data = data_q;
    // An unmapped region strobes neither port
    assign cfg_o.we   = writing && (region_q == region_t'(`DMA_REGION_CFG));

endmodule

// ==== dma/dma_read_engine.sv ====
// AXI4-Lite read master FSM that fetches one word per request into the FIFO
`include "dma_defines.svh"

module dma_read_engine
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        launch_i,
    input  addr_t       src_i,
    input  word_count_t words_i,
    input  logic        fifo_full_i,
    output axi_rd_req_t axi_req_o,
    input  axi_rd_rsp_t axi_rsp_i,
    output logic        push_o,
    output word_t       push_data_o
);

    rd_state_t   state_q;
    addr_t       addr_q;
    word_count_t remaining_q;
    logic        arvalid_q;
    logic        rready_q;
    logic        ar_hs;
    logic        r_hs;

    // Handshakes follow the AXI rule, valid and ready both high
    assign ar_hs = arvalid_q && axi_rsp_i.arready;
    assign r_hs  = rready_q && axi_rsp_i.rvalid;

    // ==================================================
    // Request FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= RD_IDLE;
            addr_q      <= '0;
            remaining_q <= '0;
            arvalid_q   <= 1'b0;
            rready_q    <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE, RD_DONE: begin
                    // Rest here until the controller launches a transfer
                    if (launch_i) begin
                        addr_q      <= src_i;
                        remaining_q <= words_i;
                        state_q     <= RD_ADDR;
                    end
                end

                RD_ADDR: begin
                    // Only request when there is room for the answer
                    if (!arvalid_q && !fifo_full_i) begin
                        arvalid_q <= 1'b1;
                    end
                    // arvalid stays up until the slave takes it
                    if (ar_hs) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= RD_DATA;
                    end
                end

                RD_DATA: begin
                    // Word is pushed on this same handshake
                    if (r_hs) begin
                        rready_q    <= 1'b0;
                        addr_q      <= addr_q + addr_t'(`DMA_WORD_BYTES);
                        remaining_q <= remaining_q - 1'b1;
                        if (remaining_q == word_count_t'(1)) begin
                            state_q <= RD_DONE;
                        end else begin
                            state_q <= RD_ADDR;
                        end
                    end
                end

                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // ==================================================
    // Outputs
    // ==================================================
    assign axi_req_o.araddr  = addr_q;
    assign axi_req_o.arvalid = arvalid_q;
    assign axi_req_o.rready  = rready_q;

    // One outstanding read, so a push never meets a full FIFO
    assign push_o      = r_hs;
    assign push_data_o = axi_rsp_i.rdata;

endmodule

// ==== dma/dma_transfer_ctrl.sv ====
// DMA transfer controller with start acceptance, word rounding and done/irq pulses
`include "dma_defines.svh"

module dma_transfer_ctrl
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dma_cfg_t    cfg_i,
    input  logic        start_i,
    input  logic        finished_i,
    output logic        launch_o,
    output word_count_t words_o,
    output logic        busy_o,
    output logic        done_o,
    output logic        irq_o
);

    // Shift that turns bytes into words
    localparam int WORD_SHIFT = $clog2(`DMA_WORD_BYTES);

    logic [32:0] size_rounded;
    logic        busy_q;
    logic        done_q;

    // ==================================================
    // Start acceptance
    // ==================================================
    // Zero size and start while busy are dropped here
    assign launch_o = start_i && (cfg_i.size != '0) && !busy_q;

    // Round bytes up to whole words, extra bit keeps the carry
    assign size_rounded = {1'b0, cfg_i.size} + 33'(`DMA_WORD_BYTES - 1);
    assign words_o      = word_count_t'(size_rounded >> WORD_SHIFT);

    // ==================================================
    // Busy and completion
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // Done is a single-cycle pulse by default
            done_q <= 1'b0;
            if (launch_o) begin
                busy_q <= 1'b1;
            end else if (busy_q && finished_i) begin
                // Busy falls on the same edge that raises done
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    // Interrupt pulses together with done
    assign irq_o  = done_q;

endmodule

// ==== dma/dma_word_fifo.sv ====
// Circular word FIFO with occupancy count and synchronous clear
`include "dma_defines.svh"

module dma_word_fifo
    import dma_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear_i,
    input  logic  push_i,
    input  word_t push_data_i,
    input  logic  pop_i,
    output word_t head_o,
    output logic  full_o,
    output logic  empty_o
);

    localparam int PTR_W = $clog2(`DMA_FIFO_DEPTH);
    // Count needs one bit more than the pointers to reach depth
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(`DMA_FIFO_DEPTH);

    word_t            mem [`DMA_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    // Guard against overflow and underflow
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Storage, no reset on the payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // ==================================================
    // Pointers and occupancy
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Head is read combinationally
    assign head_o  = mem[rd_ptr_q];
    assign full_o  = (count_q == DEPTH_CNT);
    assign empty_o = (count_q == '0);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DMA engine testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dma_tb -f verilog.f \
    && ./obj_dir/Vdma_tb 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q '\*\*\* FAILED \*\*\*' sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

// ==== sim/dma_assertions.sv ====
// Concurrent protocol assertions for the DMA engine and their bind into the top level
module dma_assertions
    import dma_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input axi_rd_req_t axi_req_i,
    input axi_rd_rsp_t axi_rsp_i,
    input tile_wr_t    tile_i,
    input cfg_wr_t     cfg_wr_i,
    input logic        busy_i,
    input logic        done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertion count
    int failures;

    // ==================================================
    // AXI read channel
    // ==================================================
    // A request stays up until the slave takes it
    a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_req_i.arvalid && !axi_rsp_i.arready |=> axi_req_i.arvalid)
        else begin
            $error("arvalid dropped before arready");
            failures++;
        end

    // Address and data phases never overlap
    a_ar_r_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(axi_req_i.arvalid && axi_req_i.rready))
        else begin
            $error("arvalid and rready high together");
            failures++;
        end

    // ==================================================
    // Local ports and completion
    // ==================================================
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(tile_i.we && cfg_wr_i.we))
        else begin
            $error("tile and config strobes high together");
            failures++;
        end

    // Done only ends a transfer that was running
    a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> $past(busy_i))
        else begin
            $error("done without busy on the previous cycle");
            failures++;
        end

endmodule

bind dma_engine_top dma_assertions u_dma_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .axi_req_i (axi_req_o),
    .axi_rsp_i (axi_rsp_i),
    .tile_i    (tile_o),
    .cfg_wr_i  (cfg_wr_o),
    .busy_i    (busy_o),
    .done_i    (done_o)
);

// ==== sim/dma_tb.sv ====
// DMA engine testbench with AXI read slave model, reference model, stimulus and checks
`include "dma_defines.svh"

module dma_tb
    import dma_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_TIMEOUT  = 2000;
    localparam int RESET_TIMEOUT = 50;

    logic        clk;
    logic        rst_n;
    dma_cfg_t    cfg;
    logic        start;
    logic        busy;
    logic        done;
    logic        irq;
    axi_rd_req_t axi_req;
    axi_rd_rsp_t axi_rsp;
    tile_wr_t    tile_wr;
    cfg_wr_t     cfg_wr;

    // Scoreboard state whose per-transfer counts reset when busy rises
    dma_cfg_t    exp_cfg;
    word_count_t tile_seen;
    word_count_t cfg_seen;
    word_count_t done_seen;
    word_count_t irq_seen;
    word_count_t busy_rises;
    word_count_t done_base;
    word_count_t irq_base;
    int          value_errors;
    int          other_errors;
    int          timeouts;
    bit          timed_out;

    dma_tb_clk u_dma_tb_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_engine_top u_dma_engine_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg),
        .start_i   (start),
        .busy_o    (busy),
        .done_o    (done),
        .irq_o     (irq),
        .axi_req_o (axi_req),
        .axi_rsp_i (axi_rsp),
        .tile_o    (tile_wr),
        .cfg_wr_o  (cfg_wr)
    );

    // ==================================================
    // Reference model
    // ==================================================
    // Source memory contents in which every address bit takes part
    function automatic word_t src_word(input addr_t a);
        return {a[15:0], ~a[31:16]} ^ (a * 32'h9E37_79B9);
    endfunction

    // Destination address and data of the k-th write
    function automatic void expected_write(input dma_cfg_t c, input word_count_t k,
                                           output addr_t dst, output word_t data);
        addr_t offset;
        offset = k * `DMA_WORD_BYTES;
        dst    = c.dst + offset;
        data   = src_word(c.src + offset);
    endfunction

    // Byte size rounded up to whole words
    function automatic word_count_t expected_words(input logic [31:0] size);
        logic [32:0] sum;
        sum = {1'b0, size} + 33'(`DMA_WORD_BYTES - 1);
        return word_count_t'(sum / 33'(`DMA_WORD_BYTES));
    endfunction

    task automatic check_tile(input tile_addr_t got_a, input tile_addr_t exp_a,
                              input bank_sel_t got_b, input bank_sel_t exp_b,
                              input word_t got_d, input word_t exp_d);
        if (got_a !== exp_a || got_b !== exp_b || got_d !== exp_d) begin
            $display("[ERROR] %0t: tile write addr %h bank %0d data %h, expected %h %0d %h",
                     $time, got_a, got_b, got_d, exp_a, exp_b, exp_d);
            value_errors++;
        end
    endtask

    task automatic check_cfg(input addr_t got_a, input addr_t exp_a,
                             input word_t got_d, input word_t exp_d);
        if (got_a !== exp_a || got_d !== exp_d) begin
            $display("[ERROR] %0t: config write addr %h data %h, expected %h %h",
                     $time, got_a, got_d, exp_a, exp_d);
            value_errors++;
        end
    endtask

    task automatic check_count(input string what, input word_count_t got,
                               input word_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // ==================================================
    // Compare process
    // ==================================================
    initial begin : compare
        addr_t exp_addr;
        word_t exp_data;
        logic  busy_d;
        tile_seen  = '0;
        cfg_seen   = '0;
        done_seen  = '0;
        irq_seen   = '0;
        busy_rises = '0;
        busy_d     = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (busy && !busy_d) begin
                    tile_seen  <= '0;
                    cfg_seen   <= '0;
                    busy_rises <= busy_rises + 1'b1;
                end
                if (tile_wr.we) begin
                    expected_write(exp_cfg, tile_seen + cfg_seen, exp_addr, exp_data);
                    if (exp_cfg.dst[31:28] != region_t'(`DMA_REGION_TILE)) begin
                        $display("Tile write at %0t outside a tile-region transfer", $time);
                        other_errors++;
                    end
                    check_tile(tile_wr.addr, exp_addr[11:0], tile_wr.bank, exp_addr[13:12],
                               tile_wr.data, exp_data);
                    tile_seen <= tile_seen + 1'b1;
                end
                if (cfg_wr.we) begin
                    expected_write(exp_cfg, tile_seen + cfg_seen, exp_addr, exp_data);
                    if (exp_cfg.dst[31:28] != region_t'(`DMA_REGION_CFG)) begin
                        $display("Config write at %0t outside a config-region transfer", $time);
                        other_errors++;
                    end
                    check_cfg(cfg_wr.addr, exp_addr, cfg_wr.data, exp_data);
                    cfg_seen <= cfg_seen + 1'b1;
                end
                if (done) begin
                    done_seen <= done_seen + 1'b1;
                end
                if (irq) begin
                    irq_seen <= irq_seen + 1'b1;
                end
            end
            busy_d = busy;
        end
    end

    // ==================================================
    // AXI4-Lite read slave with 0 to 5 extra cycles per phase
    // ==================================================
    initial begin : axi_slave
        int unsigned ar_cnt;
        int unsigned ar_lim;
        int unsigned r_cnt;
        int unsigned r_lim;
        addr_t       rd_addr;
        bit          r_pending;
        axi_rsp   = '0;
        ar_cnt    = 0;
        r_cnt     = 0;
        rd_addr   = '0;
        r_pending = 1'b0;
        // Seeds the generator once for the whole run
        ar_lim    = $urandom(32'h69) % 6;
        r_lim     = $urandom % 6;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                axi_rsp   <= '0;
                r_pending = 1'b0;
                ar_cnt    = 0;
                r_cnt     = 0;
            end else begin
                if (axi_rsp.arready && axi_req.arvalid) begin
                    axi_rsp.arready <= 1'b0;
                    rd_addr   = axi_req.araddr;
                    r_pending = 1'b1;
                    ar_cnt    = 0;
                    ar_lim    = $urandom % 6;
                end else if (axi_req.arvalid && !axi_rsp.arready && !r_pending) begin
                    if (ar_cnt >= ar_lim) axi_rsp.arready <= 1'b1;
                    else ar_cnt++;
                end
                // Data phase
                if (axi_rsp.rvalid && axi_req.rready) begin
                    axi_rsp.rvalid <= 1'b0;
                    r_pending = 1'b0;
                    r_cnt     = 0;
                    r_lim     = $urandom % 6;
                end else if (r_pending && !axi_rsp.rvalid) begin
                    if (r_cnt >= r_lim) begin
                        axi_rsp.rvalid <= 1'b1;
                        axi_rsp.rdata  <= src_word(rd_addr);
                    end else begin
                        r_cnt++;
                    end
                end
            end
        end
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic start_pulse(input dma_cfg_t c);
        @(posedge clk);
        cfg   <= c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic launch(input dma_cfg_t c);
        exp_cfg   = c;
        done_base = done_seen;
        irq_base  = irq_seen;
        start_pulse(c);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // Waits for done and then checks the write and pulse counts
    task automatic await_and_check(input dma_cfg_t c);
        word_count_t words;
        region_t     region;
        int          cycles;
        words  = expected_words(c.size);
        region = c.dst[31:28];
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout after %0d cycles waiting for done", cycles);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            if (busy) begin
                $display("Busy still high at %0t on the done cycle", $time);
                other_errors++;
            end
            // Let the compare counters settle
            @(posedge clk);
            check_count("tile writes", tile_seen,
                        (region == region_t'(`DMA_REGION_TILE)) ? words : '0);
            check_count("config writes", cfg_seen,
                        (region == region_t'(`DMA_REGION_CFG)) ? words : '0);
            check_count("done pulses", done_seen - done_base, 1);
            check_count("irq pulses", irq_seen - irq_base, 1);
        end
    endtask

    task automatic run_transfer(input dma_cfg_t c);
        if (!timed_out) begin
            launch(c);
            await_and_check(c);
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_dma_engine_top.u_dma_assertions.failures;
        $display("Errors: %0d wrong values, %0d protocol, %0d assertions, %0d timeouts",
                 value_errors, other_errors, assert_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 &&
            assert_errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : stimulus
        word_count_t rises_before;
        word_count_t done_before;
        int          cycles;
        cfg          = '0;
        start        = 1'b0;
        exp_cfg      = '0;
        done_base    = '0;
        irq_base     = '0;
        value_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        timed_out    = 1'b0;
        cycles       = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            timeouts++;
            timed_out = 1'b1;
        end else if ({axi_req.arvalid, axi_req.rready, tile_wr.we, cfg_wr.we,
                      busy, done, irq} !== '0) begin
            $display("Control outputs not low after reset");
            other_errors++;
        end
        // Tile transfer crossing from bank 1 into bank 2
        run_transfer(dma_cfg_t'{src: 32'h0000_2000, dst: 32'h1000_1FF8, size: 32'd16});
        // Size rounds up to three words
        run_transfer(dma_cfg_t'{src: 32'h0004_0000, dst: 32'h1000_0100, size: 32'd10});
        run_transfer(dma_cfg_t'{src: 32'h0000_8000, dst: 32'h2000_0040, size: 32'd20});
        // 40 words wrap the FIFO pointers several times
        run_transfer(dma_cfg_t'{src: 32'h0010_0000, dst: 32'h1000_3F80, size: 32'd160});
        if (!timed_out) begin
            launch(dma_cfg_t'{src: 32'h0000_3000, dst: 32'h1000_0200, size: 32'd16});
            idle_cycles(3);
            start_pulse(dma_cfg_t'{src: 32'h0000_5000, dst: 32'h2000_0000, size: 32'd8});
            await_and_check(dma_cfg_t'{src: 32'h0000_3000, dst: 32'h1000_0200, size: 32'd16});
            rises_before = busy_rises;
            done_before  = done_seen;
            idle_cycles(40);
            start_pulse(dma_cfg_t'{src: 32'h0000_6000, dst: 32'h1000_0000, size: 32'd0});
            idle_cycles(40);
            check_count("busy rises after ignored starts", busy_rises - rises_before, 0);
            check_count("done pulses after ignored starts", done_seen - done_before, 0);
            check_count("writes after ignored starts", tile_seen + cfg_seen, 4);
        end
        // Unmapped region still completes
        run_transfer(dma_cfg_t'{src: 32'h0002_0000, dst: 32'h7000_0000, size: 32'd12});
        finish_run();
    end

endmodule

// ==== sim/dma_tb_clk.sv ====
// Testbench clock and synchronous reset generator
module dma_tb_clk (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/dma_pkg.sv
dma/dma_transfer_ctrl.sv
dma/dma_read_engine.sv
dma/dma_word_fifo.sv
dma/dma_local_writer.sv
verilog/dma_engine_top.sv
sim/dma_tb_clk.sv
sim/dma_assertions.sv
sim/dma_tb.sv

// ==== verilog/dma_engine_top.sv ====
// DMA engine top level with controller, read engine, word FIFO and local writer
module dma_engine_top
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // CSR side
    input  dma_cfg_t    cfg_i,
    input  logic        start_i,
    output logic        busy_o,
    output logic        done_o,
    output logic        irq_o,
    // AXI4-Lite read port
    output axi_rd_req_t axi_req_o,
    input  axi_rd_rsp_t axi_rsp_i,
    // Local destinations
    output tile_wr_t    tile_o,
    output cfg_wr_t     cfg_wr_o
);

    // ==================================================
    // Internal wiring
    // ==================================================
    logic        launch;
    word_count_t words;
    logic        finished;
    logic        fifo_push;
    word_t       fifo_push_data;
    logic        fifo_pop;
    word_t       fifo_head;
    logic        fifo_full;
    logic        fifo_empty;

    dma_transfer_ctrl u_dma_transfer_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg_i),
        .start_i    (start_i),
        .finished_i (finished),
        .launch_o   (launch),
        .words_o    (words),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .irq_o      (irq_o)
    );

    // Producer, fed from the source address
    dma_read_engine u_dma_read_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .launch_i    (launch),
        .src_i       (cfg_i.src),
        .words_i     (words),
        .fifo_full_i (fifo_full),
        .axi_req_o   (axi_req_o),
        .axi_rsp_i   (axi_rsp_i),
        .push_o      (fifo_push),
        .push_data_o (fifo_push_data)
    );

    // Buffer, cleared at each launch
    dma_word_fifo u_dma_word_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (launch),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    // Consumer, routed by the destination region
    dma_local_writer u_dma_local_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .launch_i     (launch),
        .dst_i        (cfg_i.dst),
        .words_i      (words),
        .fifo_empty_i (fifo_empty),
        .fifo_head_i  (fifo_head),
        .pop_o        (fifo_pop),
        .tile_o       (tile_o),
        .cfg_o        (cfg_wr_o),
        .finished_o   (finished)
    );

endmodule
